//--- qspi_master.f
+incdir+common
common/qspi_pkg.sv
qspi_engine/qspi_sclk_gen.sv
qspi_engine/qspi_shifter.sv
qspi_engine/qspi_seq.sv
hdl/qspi_master.sv
verif/tb_qspi_bus_model.sv
verif/tb_qspi_master.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the QSPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_qspi_master \
    -f qspi_master.f -o sim_qspi_master
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_qspi_master
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished"
exit 0

//--- verif/tb_qspi_master.sv
// --------------------------------------------------------------------------
// qspi master testbench
// directed write, read, fallback and chip select tests against a bus model
// --------------------------------------------------------------------------
module tb_qspi_master;
    import qspi_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int DIV        = 1;
    localparam int N_CMDS     = 6;
    localparam int TOTAL_LEN  = 36;    // bytes over all commands
    localparam int SCLK_CLKS  = 2 * (DIV + 1);
    localparam int LIMIT      = CLK_PERIOD * (N_CMDS * (64 * SCLK_CLKS + 40)
                                + TOTAL_LEN * 8 * SCLK_CLKS + 100);

    logic      clk = 1'b0;
    logic      resetn;
    logic      start;
    logic      done;
    qspi_cfg_t cfg;
    qspi_cmd_t cmd;
    word_t     tx_data;
    logic      tx_empty;
    logic      tx_ren;
    word_t     rx_data;
    logic      rx_wen;
    logic      rx_full;
    logic      sclk;
    logic      cs_n;
    wire       io0;
    wire       io1;
    wire       io2;
    wire       io3;

    word_t tx_mem [0:15];
    word_t rx_log [0:31];
    int    tx_ptr   = 0;
    int    tx_cnt   = 0;
    int    rx_cnt   = 0;
    int    done_cnt = 0;

    qspi_master uut (
        .clk(clk), .resetn(resetn), .start(start), .done(done),
        .cfg(cfg), .cmd(cmd),
        .tx_data(tx_data), .tx_empty(tx_empty), .tx_ren(tx_ren),
        .rx_data(rx_data), .rx_wen(rx_wen), .rx_full(rx_full),
        .sclk(sclk), .cs_n(cs_n), .io0(io0), .io1(io1), .io2(io2), .io3(io3)
    );

    tb_qspi_bus_model bus (
        .sclk(sclk), .cs_n(cs_n), .cfg(cfg),
        .io0(io0), .io1(io1), .io2(io2), .io3(io3)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign tx_data = tx_mem[tx_ptr % 16];

    // FIFO side and done bookkeeping
    always @(posedge clk) begin
        if (done)
            done_cnt <= done_cnt + 1;
        if (tx_ren) begin
            tx_cnt <= tx_cnt + 1;
            tx_ptr <= tx_ptr + 1;
        end
        if (rx_wen) begin
            rx_log[rx_cnt % 32] <= rx_data;
            rx_cnt              <= rx_cnt + 1;
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_opcode(input string name, input opcode_t got, input opcode_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    function automatic qspi_cfg_t base_cfg();
        qspi_cfg_t c;
        c         = '0;
        c.clk_div = DIV;
        return c;
    endfunction

    // recorded stream bits packed MSB first
    function automatic word_t stream_value(input int first, input int count);
        word_t v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            v = {v[30:0], bus.rec_bits[first + i]};
        end
        return v;
    endfunction

    task automatic issue_cmd(input qspi_cfg_t c, input qspi_cmd_t m);
        int d0;
        d0 = done_cnt;
        @(posedge clk);
        cfg   <= c;
        cmd   <= m;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (done_cnt == d0)
            @(posedge clk);
        @(posedge clk);                   // a done longer than one clock is counted too
    endtask

    task automatic expect_rx(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("rx_data[%0d]", i), rx_log[(base + i) % 32], bus.rd_words[i]);
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic test_reset();
        check_bit("cs_n", cs_n, 1'b1);
        check_bit("sclk", sclk, cfg.cpol);
        check_bit("io0", io0, 1'bz);
        check_bit("io1", io1, 1'bz);
        check_bit("io2", io2, 1'bz);
        check_bit("io3", io3, 1'bz);
        check_bit("done", done, 1'b0);
        check_bit("tx_ren", tx_ren, 1'b0);
        check_bit("rx_wen", rx_wen, 1'b0);
    endtask

    task automatic test_single_write();
        qspi_cfg_t c;
        qspi_cmd_t m;
        word_t     w0;
        word_t     w1;
        int        t0;
        int        d0;
        c                = base_cfg();
        c.addr_bytes_sel = 2'd1;
        m.opcode         = 8'h02;
        m.addr           = $urandom;
        m.len            = 32'd8;
        w0               = $urandom;
        w1               = $urandom;
        tx_mem[tx_ptr % 16]       = w0;
        tx_mem[(tx_ptr + 1) % 16] = w1;
        t0 = tx_cnt;
        d0 = done_cnt;
        issue_cmd(c, m);
        check_word("recorded bits", word_t'(bus.rec_cnt), 32'd96);
        check_opcode("opcode", opcode_t'(stream_value(0, 8)), m.opcode);
        check_addr("addr", addr_t'(stream_value(8, 24)), {8'h00, m.addr[23:0]});
        check_word("write word 0", stream_value(32, 32), w0);
        check_word("write word 1", stream_value(64, 32), w1);
        check_word("tx_ren pulses", word_t'(tx_cnt - t0), 32'd2);
        check_word("done pulses", word_t'(done_cnt - d0), 32'd1);
    endtask

    task automatic test_quad_read();
        qspi_cfg_t c;
        qspi_cmd_t m;
        int        r0;
        c                = base_cfg();
        c.cpol           = 1'b1;
        c.cpha           = 1'b1;
        c.quad_en        = 1'b1;
        c.dir            = 1'b1;
        c.addr_lanes_sel = 2'd2;
        c.data_lanes_sel = 2'd2;
        c.addr_bytes_sel = 2'd2;
        c.dummy_cycles   = 4'd4;
        m.opcode         = 8'hEB;
        m.addr           = $urandom;
        m.len            = 32'd12;
        for (int i = 0; i < 3; i++) begin
            bus.rd_words[i] = $urandom;
        end
        r0 = rx_cnt;
        issue_cmd(c, m);
        check_word("rx_wen pulses", word_t'(rx_cnt - r0), 32'd3);
        expect_rx(r0, 3);
    endtask

    task automatic test_fallback_and_cmd_only();
        qspi_cfg_t c;
        qspi_cmd_t m;
        int        r0;
        c                = base_cfg();
        c.dir            = 1'b1;
        c.addr_bytes_sel = 2'd1;
        c.dummy_cycles   = 4'd2;
        c.data_lanes_sel = 2'd2;          // quad without quad_en
        m.opcode         = 8'h6B;
        m.addr           = $urandom;
        m.len            = 32'd8;
        bus.rd_words[0]  = $urandom;
        bus.rd_words[1]  = $urandom;
        r0 = rx_cnt;
        issue_cmd(c, m);
        check_word("rx_wen pulses", word_t'(rx_cnt - r0), 32'd2);
        expect_rx(r0, 2);

        c        = base_cfg();
        m.opcode = 8'h06;
        m.addr   = '0;
        m.len    = '0;
        issue_cmd(c, m);
        check_word("recorded bits", word_t'(bus.rec_cnt), 32'd8);
        check_opcode("opcode", opcode_t'(stream_value(0, 8)), m.opcode);
    endtask

    task automatic test_cs_and_backpressure();
        qspi_cfg_t c;
        qspi_cmd_t m;
        int        n;
        int        min_setup;
        int        r0;
        int        d0;
        c          = base_cfg();
        c.cs_delay = 2'd3;
        m.opcode   = 8'h06;
        m.addr     = '0;
        m.len      = '0;
        min_setup  = int'(c.cs_delay) + 1 + 1 + int'(c.clk_div) + 1;  // setup, arm, half period
        @(posedge clk);
        cfg   <= c;
        cmd   <= m;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (cs_n)
            @(posedge clk);
        n = 0;
        while (sclk == c.cpol) begin      // cs_n low until first sclk toggle
            n++;
            @(posedge clk);
        end
        if (n < min_setup)
            abort_run($sformatf("chip select setup too short, %0d clocks", n));
        while (!cs_n)
            @(posedge clk);
        n = 1;
        while (!done) begin
            n++;
            @(posedge clk);
        end
        if (n < 4)
            abort_run($sformatf("chip select high time before done too short, %0d clocks", n));
        @(posedge clk);

        c                = base_cfg();
        c.dir            = 1'b1;
        c.dummy_cycles   = 4'd1;
        m.opcode         = 8'h0B;
        m.len            = 32'd8;
        bus.rd_words[0]  = $urandom;
        bus.rd_words[1]  = $urandom;
        rx_full <= 1'b1;
        r0 = rx_cnt;
        d0 = done_cnt;
        issue_cmd(c, m);
        rx_full <= 1'b0;
        check_word("rx_wen pulses", word_t'(rx_cnt - r0), 32'd0);
        check_word("done pulses", word_t'(done_cnt - d0), 32'd1);
    endtask

    // watchdog
    initial begin
        #(LIMIT);
        abort_run("timeout, the tests did not complete in time");
    end

    initial begin
        void'($urandom(1950));
        resetn   = 1'b0;
        start    = 1'b0;
        cfg      = base_cfg();
        cmd      = '0;
        tx_empty = 1'b0;
        rx_full  = 1'b0;
        for (int i = 0; i < 16; i++) begin
            tx_mem[i] = '0;
        end
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        test_reset();
        test_single_write();
        test_quad_read();
        test_fallback_and_cmd_only();
        test_cs_and_backpressure();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verif/tb_qspi_bus_model.sv
// --------------------------------------------------------------------------
// qspi bus model
// flash side of the bus, records io bits on sample edges and returns
// read words in the data phase
// --------------------------------------------------------------------------
module tb_qspi_bus_model
    import qspi_pkg::*;
(
    input  logic      sclk,
    input  logic      cs_n,
    input  qspi_cfg_t cfg,
    inout  wire       io0,
    inout  wire       io1,
    inout  wire       io2,
    inout  wire       io3
);

    word_t      rd_words [0:7];    // read data, filled by the testbench
    logic       rec_bits [0:255];  // bit stream seen on sample edges
    int         rec_cnt   = 0;
    int         n_samp    = 0;
    int         rd_pos    = 0;
    logic       consumed  = 1'b0;  // current bits were sampled
    logic       drv_en    = 1'b0;
    io_nibble_t drv_bits  = '0;
    io_nibble_t drv_mask  = '0;
    logic       last_cs   = 1'b1;
    logic       last_sclk = 1'b0;

    // quad falls back to one lane without quad_en
    function automatic int lanes_of(input logic [1:0] sel);
        if (sel == 2'd0)
            return 1;
        if (sel == 2'd1)
            return 2;
        return cfg.quad_en ? 4 : 1;
    endfunction

    function automatic int addr_bits();
        if (cfg.addr_bytes_sel == 2'd1)
            return 24;
        if (cfg.addr_bytes_sel == 2'd2)
            return 32;
        return 0;
    endfunction

    task automatic record_lanes(input int lanes);
        io_nibble_t pins;
        pins = {io3, io2, io1, io0};
        for (int j = lanes - 1; j >= 0; j--) begin   // MSB lane first
            rec_bits[rec_cnt] = pins[j];
            rec_cnt++;
        end
    endtask

    task automatic present_next(input int lanes);
        word_t w;
        drv_bits = '0;
        for (int j = 0; j < lanes; j++) begin
            w = rd_words[(rd_pos / 32) % 8];
            if (lanes == 1)
                drv_bits[1] = w[31 - (rd_pos % 32)];   // single lane reads use io1
            else
                drv_bits[lanes - 1 - j] = w[31 - (rd_pos % 32)];
            rd_pos++;
        end
        drv_mask = (lanes == 4) ? 4'b1111 : (lanes == 2) ? 4'b0011 : 4'b0010;
        drv_en   = 1'b1;
    endtask

    always @(sclk or cs_n) begin
        int cmd_end;
        int addr_end;
        int pre;
        logic leading;
        cmd_end  = 8 / lanes_of(cfg.cmd_lanes_sel);
        addr_end = cmd_end + addr_bits() / lanes_of(cfg.addr_lanes_sel);
        pre      = addr_end + int'(cfg.dummy_cycles);
        leading  = (sclk != cfg.cpol);
        if (cs_n) begin
            drv_en = 1'b0;
        end else if (last_cs) begin                // new command
            n_samp   = 0;
            rec_cnt  = 0;
            rd_pos   = 0;
            consumed = 1'b0;
        end else if (sclk !== last_sclk) begin
            if (leading != cfg.cpha) begin         // sample edge
                if (n_samp < cmd_end)
                    record_lanes(lanes_of(cfg.cmd_lanes_sel));
                else if (n_samp < addr_end)
                    record_lanes(lanes_of(cfg.addr_lanes_sel));
                else if (n_samp >= pre && !cfg.dir)
                    record_lanes(lanes_of(cfg.data_lanes_sel));
                else if (n_samp >= pre)
                    consumed = 1'b1;
                n_samp++;
                if (cfg.dir && n_samp == pre)
                    present_next(lanes_of(cfg.data_lanes_sel));
            end else if (drv_en && consumed) begin
                present_next(lanes_of(cfg.data_lanes_sel));
                consumed = 1'b0;
            end
        end
        last_cs   = cs_n;
        last_sclk = sclk;
    end

    assign io0 = (drv_en && drv_mask[0]) ? drv_bits[0] : 1'bz;
    assign io1 = (drv_en && drv_mask[1]) ? drv_bits[1] : 1'bz;
    assign io2 = (drv_en && drv_mask[2]) ? drv_bits[2] : 1'bz;
    assign io3 = (drv_en && drv_mask[3]) ? drv_bits[3] : 1'bz;

endmodule

//--- hdl/qspi_master.sv
// --------------------------------------------------------------------------
// qspi master
// QSPI flash transaction engine top with sequencer, sclk generator,
// shifter and the io pin drivers
// --------------------------------------------------------------------------
module qspi_master
    import qspi_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,
    output logic      done,
    input  qspi_cfg_t cfg,
    input  qspi_cmd_t cmd,
    input  word_t     tx_data,
    input  logic      tx_empty,
    output logic      tx_ren,
    output word_t     rx_data,
    output logic      rx_wen,
    input  logic      rx_full,
    output logic      sclk,
    output logic      cs_n,
    inout  wire       io0,
    inout  wire       io1,
    inout  wire       io2,
    inout  wire       io3
);

    logic        sclk_en;
    sclk_edges_t edges;
    shift_ctrl_t ctrl;
    logic        phase_end;
    word_t       shreg_word;
    io_nibble_t  io_out;
    io_nibble_t  io_oe;
    io_nibble_t  io_in;

    qspi_seq u_seq (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .done       (done),
        .cfg        (cfg),
        .cmd        (cmd),
        .edges      (edges),
        .phase_end  (phase_end),
        .shreg_word (shreg_word),
        .tx_data    (tx_data),
        .tx_empty   (tx_empty),
        .tx_ren     (tx_ren),
        .rx_data    (rx_data),
        .rx_wen     (rx_wen),
        .rx_full    (rx_full),
        .sclk_en    (sclk_en),
        .cs_n       (cs_n),
        .ctrl       (ctrl)
    );

    qspi_sclk_gen u_sclk_gen (
        .clk     (clk),
        .resetn  (resetn),
        .sclk_en (sclk_en),
        .clk_div (cfg.clk_div),
        .cpol    (cfg.cpol),
        .cpha    (cfg.cpha),
        .sclk    (sclk),
        .edges   (edges)
    );

    qspi_shifter u_shifter (
        .clk        (clk),
        .resetn     (resetn),
        .ctrl       (ctrl),
        .edges      (edges),
        .cpha       (cfg.cpha),
        .io_in      (io_in),
        .io_out     (io_out),
        .io_oe      (io_oe),
        .phase_end  (phase_end),
        .shreg_word (shreg_word)
    );

    // pin drivers, released lanes float for the flash
    assign io0   = io_oe[0] ? io_out[0] : 1'bz;
    assign io1   = io_oe[1] ? io_out[1] : 1'bz;
    assign io2   = io_oe[2] ? io_out[2] : 1'bz;
    assign io3   = io_oe[3] ? io_out[3] : 1'bz;
    assign io_in = {io3, io2, io1, io0};

endmodule

//--- qspi_engine/qspi_seq.sv
// --------------------------------------------------------------------------
// qspi sequencer
// walks command, address, dummy and data phases of one flash command,
// controls chip select and issues the tx/rx FIFO strobes
// --------------------------------------------------------------------------
`include "qspi_macros.svh"

module qspi_seq
    import qspi_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        start,
    output logic        done,
    input  qspi_cfg_t   cfg,
    input  qspi_cmd_t   cmd,
    input  sclk_edges_t edges,
    input  logic        phase_end,
    input  word_t       shreg_word,
    input  word_t       tx_data,
    input  logic        tx_empty,
    output logic        tx_ren,
    output word_t       rx_data,
    output logic        rx_wen,
    input  logic        rx_full,
    output logic        sclk_en,
    output logic        cs_n,
    output shift_ctrl_t ctrl
);

    seq_state_t               state, state_n;
    logic [`QSPI_CSCNT_W-1:0] cs_cnt, cs_cnt_n;
    logic [3:0]               dummy_cnt, dummy_cnt_n;
    len_t                     byte_cnt, byte_cnt_n;
    len_t                     byte_cnt_inc;
    lane_cnt_t                cmd_lanes, addr_lanes, data_lanes;
    bit_cnt_t                 addr_bits;
    word_t                    addr_word;
    word_t                    tx_word;        // zeros when the FIFO ran dry
    seq_state_t               data_or_done;
    seq_state_t               post_addr;

    // quad falls back to single lane unless enabled
    function automatic lane_cnt_t lane_decode(input logic [1:0] sel, input logic quad_en);
        case (sel)
            2'd0:    return 3'd1;
            2'd1:    return 3'd2;
            default: return quad_en ? 3'd4 : 3'd1;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // configuration decode
    // ----------------------------------------------------------------------
    assign cmd_lanes  = lane_decode(cfg.cmd_lanes_sel, cfg.quad_en);
    assign addr_lanes = lane_decode(cfg.addr_lanes_sel, cfg.quad_en);
    assign data_lanes = lane_decode(cfg.data_lanes_sel, cfg.quad_en);

    assign addr_bits = (cfg.addr_bytes_sel == 2'd1) ? bit_cnt_t'(24) :
                       (cfg.addr_bytes_sel == 2'd2) ? bit_cnt_t'(32) : '0;
    assign addr_word = (cfg.addr_bytes_sel == 2'd1) ? {cmd.addr[23:0], 8'h00} : cmd.addr;

    assign tx_word      = tx_empty ? '0 : tx_data;
    assign byte_cnt_inc = byte_cnt + len_t'(`QSPI_WORD_BITS / 8);
    assign data_or_done = (cmd.len == '0) ? CS_DONE : (cfg.dir ? RD_SETUP : WR_SETUP);
    assign post_addr    = (cfg.dummy_cycles != '0) ? DUMMY : data_or_done;

    assign sclk_en = (state == CMD) || (state == ADDR) || (state == DUMMY) || (state == DATA);
    assign done    = (state == CS_DONE) && (cs_cnt == '0);
    assign rx_data = shreg_word;

    // ----------------------------------------------------------------------
    // next state and shifter orders
    // ----------------------------------------------------------------------
    always_comb begin
        state_n        = state;
        cs_cnt_n       = cs_cnt;
        dummy_cnt_n    = dummy_cnt;
        byte_cnt_n     = byte_cnt;
        tx_ren         = 1'b0;
        rx_wen         = 1'b0;
        ctrl.load      = 1'b0;
        ctrl.load_word = '0;
        ctrl.active    = (state == CMD) || (state == ADDR) || (state == DATA);
        ctrl.drive     = (state == CMD) || (state == ADDR) || (state == DATA && !cfg.dir);

        case (state)
            CMD:     ctrl.lanes = cmd_lanes;
            ADDR:    ctrl.lanes = addr_lanes;
            default: ctrl.lanes = data_lanes;
        endcase
        case (state)
            CMD:     ctrl.phase_bits = bit_cnt_t'(`QSPI_CMD_BITS);
            ADDR:    ctrl.phase_bits = addr_bits;
            default: ctrl.phase_bits = bit_cnt_t'(`QSPI_WORD_BITS);
        endcase

        case (state)
            IDLE: if (start) begin
                state_n        = CS_SETUP;
                cs_cnt_n       = cfg.cs_delay;
                ctrl.load      = 1'b1;
                ctrl.load_word = {cmd.opcode, {(`QSPI_WORD_BITS-`QSPI_CMD_BITS){1'b0}}};
            end
            CS_SETUP: begin
                if (cs_cnt != '0)
                    cs_cnt_n = cs_cnt - 1'b1;
                else
                    state_n = CMD;
            end
            CMD: if (phase_end) begin
                if (addr_bits != '0) begin
                    state_n        = ADDR;
                    ctrl.load      = 1'b1;
                    ctrl.load_word = addr_word;
                end else begin
                    state_n = post_addr;
                end
            end
            ADDR: if (phase_end)
                state_n = post_addr;
            DUMMY: if (edges.sample) begin
                if (dummy_cnt == 4'd1)
                    state_n = data_or_done;
                else
                    dummy_cnt_n = dummy_cnt - 1'b1;
            end
            WR_SETUP: begin                       // first word from the tx FIFO
                state_n        = DATA;
                byte_cnt_n     = '0;
                ctrl.load      = 1'b1;
                ctrl.load_word = tx_word;
                tx_ren         = !tx_empty;
            end
            RD_SETUP: begin                       // io already released here
                state_n    = DATA;
                byte_cnt_n = '0;
                ctrl.load  = 1'b1;
            end
            DATA: if (phase_end) begin
                byte_cnt_n = byte_cnt_inc;
                rx_wen     = cfg.dir && !rx_full;  // full FIFO drops the word
                if (byte_cnt_inc >= cmd.len) begin
                    state_n = CS_DONE;
                end else if (!cfg.dir) begin
                    ctrl.load      = 1'b1;
                    ctrl.load_word = tx_word;
                    tx_ren         = !tx_empty;
                end
            end
            CS_DONE: begin
                if (cs_cnt != '0)
                    cs_cnt_n = cs_cnt - 1'b1;
                else
                    state_n = IDLE;
            end
            default: state_n = IDLE;
        endcase

        // counters loaded on phase entry
        if (state_n == DUMMY && state != DUMMY)
            dummy_cnt_n = cfg.dummy_cycles;
        if (state_n == CS_DONE && state != CS_DONE)
            cs_cnt_n = cfg.cs_delay;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= IDLE;
            cs_cnt    <= '0;
            dummy_cnt <= '0;
            byte_cnt  <= '0;
            cs_n      <= 1'b1;
        end else begin
            state     <= state_n;
            cs_cnt    <= cs_cnt_n;
            dummy_cnt <= dummy_cnt_n;
            byte_cnt  <= byte_cnt_n;
            cs_n      <= (state_n == IDLE) || (state_n == CS_DONE);
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    a_tx_ren_write : assert property (@(posedge clk) disable iff (!resetn)
        tx_ren |-> (!cfg.dir && (state == WR_SETUP || state == DATA)));

    a_rx_wen_read : assert property (@(posedge clk) disable iff (!resetn)
        rx_wen |-> (cfg.dir && state == DATA));

    a_cs_low_with_sclk : assert property (@(posedge clk) disable iff (!resetn)
        sclk_en |-> !cs_n);

endmodule

//--- qspi_engine/qspi_shifter.sv
// --------------------------------------------------------------------------
// qspi shifter
// lane aware shift register with bit counter, drives and captures the
// four io lines MSB first
// --------------------------------------------------------------------------
`include "qspi_macros.svh"

module qspi_shifter
    import qspi_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  shift_ctrl_t ctrl,
    input  sclk_edges_t edges,
    input  logic        cpha,
    input  io_nibble_t  io_in,
    output io_nibble_t  io_out,
    output io_nibble_t  io_oe,
    output logic        phase_end,
    output word_t       shreg_word
);

    localparam int MSB = `QSPI_WORD_BITS - 1;

    word_t      shreg;
    bit_cnt_t   bit_cnt;
    bit_cnt_t   bit_cnt_next;
    logic       skip_shift;   // hold the MSB over the next shift edge
    io_nibble_t in_bits;
    io_nibble_t lane_mask;

    // ----------------------------------------------------------------------
    // lane mapping
    // ----------------------------------------------------------------------
    always_comb begin
        case (ctrl.lanes)
            3'd2: begin
                io_out    = {2'b00, shreg[MSB], shreg[MSB-1]};
                in_bits   = {2'b00, io_in[1:0]};
                lane_mask = 4'b0011;
            end
            3'd4: begin
                io_out    = shreg[MSB:MSB-3];
                in_bits   = io_in;
                lane_mask = 4'b1111;
            end
            default: begin
                io_out    = {3'b000, shreg[MSB]};   // out on io0
                in_bits   = {3'b000, io_in[1]};     // in from io1
                lane_mask = 4'b0001;
            end
        endcase
    end

    assign io_oe        = ctrl.drive ? lane_mask : 4'b0000;
    assign shreg_word   = (shreg << ctrl.lanes) | word_t'(in_bits);   // word incl. this sample
    assign bit_cnt_next = bit_cnt + bit_cnt_t'(ctrl.lanes);
    assign phase_end    = ctrl.active & edges.sample & (bit_cnt_next >= ctrl.phase_bits);

    always_ff @(posedge clk) begin
        if (ctrl.load)
            shreg <= ctrl.load_word;
        else if (ctrl.active && edges.sample && !ctrl.drive)
            shreg <= shreg_word;                    // read capture
        else if (ctrl.active && edges.shift && ctrl.drive && !skip_shift)
            shreg <= shreg << ctrl.lanes;
    end

    // a load on a sample edge, or any load in cpha=1, is followed by a shift
    // edge that must not move the fresh MSB away
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            bit_cnt    <= '0;
            skip_shift <= 1'b0;
        end else if (ctrl.load) begin
            bit_cnt    <= '0;
            skip_shift <= cpha | edges.sample;
        end else if (ctrl.active) begin
            if (edges.shift)
                skip_shift <= 1'b0;
            if (edges.sample)
                bit_cnt <= phase_end ? '0 : bit_cnt_next;
        end
    end

    a_lanes_legal : assert property (@(posedge clk) disable iff (!resetn)
        ctrl.active |-> (ctrl.lanes == 3'd1 || ctrl.lanes == 3'd2 || ctrl.lanes == 3'd4));

endmodule

//--- qspi_engine/qspi_sclk_gen.sv
// --------------------------------------------------------------------------
// qspi sclk generator
// divides the core clock into sclk and marks sample and shift edges
// according to cpol and cpha
// --------------------------------------------------------------------------
`include "qspi_macros.svh"

module qspi_sclk_gen
    import qspi_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   sclk_en,
    input  logic [`QSPI_DIV_W-1:0] clk_div,
    input  logic                   cpol,
    input  logic                   cpha,
    output logic                   sclk,
    output sclk_edges_t            edges
);

    logic [`QSPI_DIV_W-1:0] div_cnt;
    logic                   armed;     // one idle cycle after enable
    logic                   sclk_q;
    logic                   toggle_q;  // sclk_q changed this cycle
    logic                   lead_q;    // that change left the idle level

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            div_cnt  <= '0;
            armed    <= 1'b0;
            sclk_q   <= 1'b0;
            toggle_q <= 1'b0;
            lead_q   <= 1'b0;
        end else begin
            toggle_q <= 1'b0;
            if (!sclk_en) begin
                div_cnt <= '0;
                armed   <= 1'b0;
                sclk_q  <= cpol;
            end else if (!armed) begin
                armed   <= 1'b1;
                div_cnt <= '0;
            end else if (div_cnt >= clk_div) begin
                div_cnt  <= '0;
                sclk_q   <= ~sclk_q;
                toggle_q <= 1'b1;
                lead_q   <= (sclk_q == cpol);
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    assign sclk = sclk_en ? sclk_q : cpol;

    // mode 0/2 sample on the leading edge, mode 1/3 on the trailing one
    assign edges.sample = sclk_en & toggle_q & (cpha ? ~lead_q : lead_q);
    assign edges.shift  = sclk_en & toggle_q & (cpha ? lead_q : ~lead_q);

    a_edges_exclusive : assert property (@(posedge clk) disable iff (!resetn)
        !(edges.sample && edges.shift));

endmodule

//--- common/qspi_pkg.sv
// --------------------------------------------------------------------------
// qspi package
// vector types, control structs and sequencer states of the QSPI engine
// --------------------------------------------------------------------------
`include "qspi_macros.svh"

package qspi_pkg;

    typedef logic [`QSPI_WORD_BITS-1:0]  word_t;
    typedef logic [`QSPI_CMD_BITS-1:0]   opcode_t;
    typedef logic [`QSPI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [31:0]                 len_t;        // transfer length in bytes
    typedef logic [2:0]                  lane_cnt_t;   // 1, 2 or 4
    typedef logic [3:0]                  io_nibble_t;  // io3..io0
    typedef logic [`QSPI_BITCNT_W-1:0]   bit_cnt_t;

    // static configuration, held stable for a whole command
    typedef struct packed {
        logic [1:0]             cmd_lanes_sel;
        logic [1:0]             addr_lanes_sel;
        logic [1:0]             data_lanes_sel;
        logic [1:0]             addr_bytes_sel;  // 0 none, 1 three bytes, 2 four bytes
        logic [3:0]             dummy_cycles;
        logic                   dir;             // 0 write, 1 read
        logic                   quad_en;
        logic [1:0]             cs_delay;
        logic                   cpol;
        logic                   cpha;
        logic [`QSPI_DIV_W-1:0] clk_div;
    } qspi_cfg_t;

    typedef struct packed {
        opcode_t opcode;
        addr_t   addr;
        len_t    len;
    } qspi_cmd_t;

    typedef struct packed {
        logic sample;
        logic shift;
    } sclk_edges_t;

    // ---------------------------------------------------------------------
    // orders from the sequencer to the shifter
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic      load;        // pulse
        word_t     load_word;
        lane_cnt_t lanes;
        bit_cnt_t  phase_bits;
        logic      drive;       // io output enable
        logic      active;      // count and shift
    } shift_ctrl_t;

    typedef enum logic [3:0] {
        IDLE,
        CS_SETUP,
        CMD,
        ADDR,
        DUMMY,
        WR_SETUP,
        RD_SETUP,
        DATA,
        CS_DONE
    } seq_state_t;

endpackage

//--- common/qspi_macros.svh
// --------------------------------------------------------------------------
// qspi macros
// widths and counts shared by the QSPI transaction engine
// --------------------------------------------------------------------------
`ifndef QSPI_MACROS_SVH
`define QSPI_MACROS_SVH

// data path
`define QSPI_WORD_BITS   32    // one data word
`define QSPI_CMD_BITS    8     // opcode, always single phase of 8 bits
`define QSPI_ADDR_WIDTH  32    // flash address

// counters
`define QSPI_BITCNT_W    6     // bit position inside one phase
`define QSPI_CSCNT_W     2     // chip select setup / high time
`define QSPI_DIV_W       32    // sclk divider

`endif
